// ==== logic/creg_pkg.sv ====
// Shared types for the control-register subsystem
// Four threads per core; index and bitmap widths follow from that count

package creg_pkg;

	localparam int THREADS_PER_CORE = 4;
	localparam int ASID_WIDTH = 8;

	typedef logic [31:0] scalar_t;
	typedef logic [$clog2(THREADS_PER_CORE)-1:0] thread_idx_t;
	typedef logic [THREADS_PER_CORE-1:0] thread_bitmap_t;
	typedef logic [3:0] subcycle_t;

	typedef enum logic [3:0] {
		TR_RESET,
		TR_ILLEGAL_INSTRUCTION,
		TR_PRIVILEGED_OP,
		TR_ITLB_MISS,
		TR_DTLB_MISS,
		TR_PAGE_FAULT,
		TR_SYSCALL
	} trap_reason_t;

	// Undefined indices are legal and read back as all ones
	typedef enum logic [4:0] {
		CR_THREAD_ID = 5'd0,
		CR_FLAGS,
		CR_SAVED_FLAGS,
		CR_TRAP_PC,
		CR_TRAP_REASON,
		CR_TRAP_HANDLER,
		CR_TRAP_ADDRESS,
		CR_TLB_MISS_HANDLER,
		CR_CYCLE_COUNT,
		CR_SCRATCHPAD0,
		CR_SCRATCHPAD1,
		CR_SUBCYCLE,
		CR_CURRENT_ASID
	} control_register_t;

	typedef enum logic [1:0] {
		OP_READ,
		OP_WRITE,
		OP_TRAP,
		OP_ERET
	} creg_op_t;

	// Flags view of a register word with interrupt enable in bit 0
	typedef struct packed {
		logic [28:0] reserved;
		logic supervisor_en;
		logic mmu_en;
		logic interrupt_en;
	} flags_t;

	typedef union packed {
		scalar_t raw;
		flags_t flags;
	} creg_value_u;

	typedef struct packed {
		creg_op_t op;
		thread_idx_t thread;
		control_register_t index;
		creg_value_u value;
		trap_reason_t trap_reason;
		scalar_t trap_pc;
		scalar_t trap_addr;
		subcycle_t subcycle;
	} creg_request_t;

	typedef struct packed {
		thread_idx_t thread;
		trap_reason_t reason;
		scalar_t pc;
		scalar_t access_addr;
		subcycle_t subcycle;
	} trap_event_t;

	typedef struct packed {
		thread_idx_t thread;
		scalar_t pc;
		subcycle_t subcycle;
	} redirect_t;

endpackage

// ==== logic/creg_access_port.sv ====
// One request per cycle with no back-pressure; strobes come one cycle after the request
// Privilege is checked against the flags as they stand when the strobe goes out

`timescale 1ns/1ps

module creg_access_port
	(input                              clk,
	input                               reset,
	input                               req_valid,
	input creg_pkg::creg_request_t      req,
	input creg_pkg::thread_bitmap_t     supervisor_en,
	output logic                        rd_en,
	output logic                        wr_en,
	output logic                        eret_en,
	output logic                        trap_en,
	output creg_pkg::thread_idx_t       acc_thread,
	output creg_pkg::control_register_t acc_index,
	output creg_pkg::creg_value_u       acc_value,
	output creg_pkg::trap_event_t       trap);

	import creg_pkg::*;

	logic valid_q;
	creg_request_t req_q;
	logic user_mode;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			valid_q <= 1'b0;
		else
			valid_q <= req_valid;
	end

	always_ff @(posedge clk)
	begin
		if (req_valid)
			req_q <= req;
	end

	assign user_mode = !supervisor_en[req_q.thread];
	assign acc_thread = req_q.thread;
	assign acc_index = req_q.index;
	assign acc_value = req_q.value;

	always_comb
	begin
		rd_en = 1'b0;
		wr_en = 1'b0;
		eret_en = 1'b0;
		trap_en = 1'b0;

		// Thread travels with every operation since the redirect for a return needs it
		trap.thread = req_q.thread;
		trap.reason = req_q.trap_reason;
		trap.pc = req_q.trap_pc;
		trap.access_addr = req_q.trap_addr;
		trap.subcycle = req_q.subcycle;

		if (valid_q)
		begin
			if (req_q.op != OP_TRAP && user_mode)
			begin
				// Register access or return from user mode
				trap_en = 1'b1;
				trap.reason = TR_PRIVILEGED_OP;
				trap.access_addr = '0;
				trap.subcycle = '0;
			end
			else
			begin
				case (req_q.op)
					OP_READ:  rd_en = 1'b1;
					OP_WRITE: wr_en = 1'b1;
					OP_TRAP:  trap_en = 1'b1;
					default:  eret_en = 1'b1;
				endcase
			end
		end
	end

endmodule

// ==== logic/control_registers.sv ====
// Per-thread and shared control registers; state changes on the edge ending a strobe
// Read data is registered, so it appears together with the updated state
// TRAP_REASON, TRAP_ADDRESS, CYCLE_COUNT and THREAD_ID are read only

`timescale 1ns/1ps

module control_registers
	#(parameter int CORE_ID = 0)
	(input                              clk,
	input                               reset,
	input                               rd_en,
	input                               wr_en,
	input                               eret_en,
	input                               trap_en,
	input creg_pkg::thread_idx_t        acc_thread,
	input creg_pkg::control_register_t  acc_index,
	input creg_pkg::creg_value_u        acc_value,
	input creg_pkg::trap_event_t        trap,
	output logic                        read_valid,
	output creg_pkg::scalar_t           read_data,
	output creg_pkg::thread_bitmap_t    supervisor_en,
	output creg_pkg::thread_bitmap_t    mmu_en,
	output creg_pkg::thread_bitmap_t    interrupt_en,
	output logic [creg_pkg::THREADS_PER_CORE-1:0][creg_pkg::ASID_WIDTH-1:0] current_asid,
	output creg_pkg::scalar_t           eret_address,
	output creg_pkg::subcycle_t         eret_subcycle,
	output creg_pkg::scalar_t           trap_handler,
	output creg_pkg::scalar_t           tlb_miss_handler);

	import creg_pkg::*;

	thread_bitmap_t saved_supervisor_en;
	thread_bitmap_t saved_mmu_en;
	thread_bitmap_t saved_interrupt_en;
	scalar_t trap_pc[THREADS_PER_CORE];
	trap_reason_t trap_reason[THREADS_PER_CORE];
	scalar_t trap_addr[THREADS_PER_CORE];
	subcycle_t subcycle[THREADS_PER_CORE];
	scalar_t scratchpad[2][THREADS_PER_CORE];
	scalar_t cycle_count;
	creg_value_u cur_flags;
	creg_value_u prev_flags;
	logic tlb_miss;

	// Flags of the accessing thread packed into register words
	always_comb
	begin
		cur_flags.raw = '0;
		cur_flags.flags.supervisor_en = supervisor_en[acc_thread];
		cur_flags.flags.mmu_en = mmu_en[acc_thread];
		cur_flags.flags.interrupt_en = interrupt_en[acc_thread];
		prev_flags.raw = '0;
		prev_flags.flags.supervisor_en = saved_supervisor_en[acc_thread];
		prev_flags.flags.mmu_en = saved_mmu_en[acc_thread];
		prev_flags.flags.interrupt_en = saved_interrupt_en[acc_thread];
	end

	assign tlb_miss = trap.reason == TR_ITLB_MISS || trap.reason == TR_DTLB_MISS;
	assign eret_address = trap_pc[acc_thread];
	assign eret_subcycle = subcycle[acc_thread];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			// Threads come up in supervisor mode with translation off
			supervisor_en <= '1;
			mmu_en <= '0;
			interrupt_en <= '0;
			saved_supervisor_en <= '0;
			saved_mmu_en <= '0;
			saved_interrupt_en <= '0;
			current_asid <= '0;
			for (int i = 0; i < THREADS_PER_CORE; i++)
			begin
				trap_pc[i] <= '0;
				trap_reason[i] <= TR_RESET;
				trap_addr[i] <= '0;
				subcycle[i] <= '0;
				scratchpad[0][i] <= '0;
				scratchpad[1][i] <= '0;
			end
			trap_handler <= '0;
			tlb_miss_handler <= '0;
			cycle_count <= '0;
			read_valid <= 1'b0;
			read_data <= '0;
		end
		else
		begin
			cycle_count <= cycle_count + 1'b1;
			read_valid <= rd_en;

			if (trap_en)
			begin
				saved_supervisor_en[trap.thread] <= supervisor_en[trap.thread];
				saved_mmu_en[trap.thread] <= mmu_en[trap.thread];
				saved_interrupt_en[trap.thread] <= interrupt_en[trap.thread];
				trap_pc[trap.thread] <= trap.pc;
				trap_reason[trap.thread] <= trap.reason;
				trap_addr[trap.thread] <= trap.access_addr;
				subcycle[trap.thread] <= trap.subcycle;
				supervisor_en[trap.thread] <= 1'b1;
				interrupt_en[trap.thread] <= 1'b0;

				// Handler must run untranslated after a TLB miss
				if (tlb_miss)
					mmu_en[trap.thread] <= 1'b0;
			end
			else if (eret_en)
			begin
				supervisor_en[acc_thread] <= saved_supervisor_en[acc_thread];
				mmu_en[acc_thread] <= saved_mmu_en[acc_thread];
				interrupt_en[acc_thread] <= saved_interrupt_en[acc_thread];
			end
			else if (wr_en)
			begin
				case (acc_index)
					CR_FLAGS:
					begin
						supervisor_en[acc_thread] <= acc_value.flags.supervisor_en;
						mmu_en[acc_thread] <= acc_value.flags.mmu_en;
						interrupt_en[acc_thread] <= acc_value.flags.interrupt_en;
					end

					CR_SAVED_FLAGS:
					begin
						saved_supervisor_en[acc_thread] <= acc_value.flags.supervisor_en;
						saved_mmu_en[acc_thread] <= acc_value.flags.mmu_en;
						saved_interrupt_en[acc_thread] <= acc_value.flags.interrupt_en;
					end

					CR_TRAP_PC:          trap_pc[acc_thread] <= acc_value.raw;
					CR_TRAP_HANDLER:     trap_handler <= acc_value.raw;
					CR_TLB_MISS_HANDLER: tlb_miss_handler <= acc_value.raw;
					CR_SCRATCHPAD0:      scratchpad[0][acc_thread] <= acc_value.raw;
					CR_SCRATCHPAD1:      scratchpad[1][acc_thread] <= acc_value.raw;
					CR_SUBCYCLE:         subcycle[acc_thread] <= subcycle_t'(acc_value.raw);
					CR_CURRENT_ASID:
						current_asid[acc_thread] <= acc_value.raw[ASID_WIDTH-1:0];
					default:
						;
				endcase
			end

			if (rd_en)
			begin
				case (acc_index)
					CR_THREAD_ID:
						read_data <= (scalar_t'(CORE_ID) << $bits(thread_idx_t))
							| scalar_t'(acc_thread);
					CR_FLAGS:            read_data <= cur_flags.raw;
					CR_SAVED_FLAGS:      read_data <= prev_flags.raw;
					CR_TRAP_PC:          read_data <= trap_pc[acc_thread];
					CR_TRAP_REASON:      read_data <= scalar_t'(trap_reason[acc_thread]);
					CR_TRAP_HANDLER:     read_data <= trap_handler;
					CR_TRAP_ADDRESS:     read_data <= trap_addr[acc_thread];
					CR_TLB_MISS_HANDLER: read_data <= tlb_miss_handler;
					CR_CYCLE_COUNT:      read_data <= cycle_count;
					CR_SCRATCHPAD0:      read_data <= scratchpad[0][acc_thread];
					CR_SCRATCHPAD1:      read_data <= scratchpad[1][acc_thread];
					CR_SUBCYCLE:         read_data <= scalar_t'(subcycle[acc_thread]);
					CR_CURRENT_ASID:     read_data <= scalar_t'(current_asid[acc_thread]);
					default:             read_data <= '1;
				endcase
			end
		end
	end

	// Both come from one request slot, so they can never coincide
	assert property (@(posedge clk) disable iff (reset) !(trap_en && eret_en))
		else $error("trap and return in the same cycle");

	assert property (@(posedge clk) disable iff (reset) !(rd_en && wr_en))
		else $error("register read and write in the same cycle");

endmodule

// ==== logic/trap_redirect.sv ====
// Fetch redirect, registered on the same edge that updates the trap state
// Handler and saved pc are sampled before that edge

`timescale 1ns/1ps

module trap_redirect
	(input                          clk,
	input                           reset,
	input                           trap_en,
	input                           eret_en,
	input creg_pkg::trap_event_t    trap,
	input creg_pkg::scalar_t        trap_handler,
	input creg_pkg::scalar_t        tlb_miss_handler,
	input creg_pkg::scalar_t        eret_address,
	input creg_pkg::subcycle_t      eret_subcycle,
	output logic                    redirect_valid,
	output creg_pkg::redirect_t     redirect);

	import creg_pkg::*;

	redirect_t next_redirect;

	always_comb
	begin
		// On a return the event carries only the thread
		next_redirect.thread = trap.thread;
		if (trap_en)
		begin
			if (trap.reason == TR_ITLB_MISS || trap.reason == TR_DTLB_MISS)
				next_redirect.pc = tlb_miss_handler;
			else
				next_redirect.pc = trap_handler;

			next_redirect.subcycle = '0;
		end
		else
		begin
			// Resume the faulting instruction where it left off
			next_redirect.pc = eret_address;
			next_redirect.subcycle = eret_subcycle;
		end
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			redirect_valid <= 1'b0;
			redirect <= '0;
		end
		else
		begin
			redirect_valid <= trap_en || eret_en;
			if (trap_en || eret_en)
				redirect <= next_redirect;
		end
	end

endmodule

// ==== logic/creg_subsys_top.sv ====
// Control-register subsystem of one core, fixed two-cycle latency for every operation
// CORE_ID appears in the upper bits of CR_THREAD_ID reads

`timescale 1ns/1ps

module creg_subsys_top
	#(parameter int CORE_ID = 3)
	(input                              clk,
	input                               reset,
	input                               req_valid,
	input creg_pkg::creg_request_t      req,
	output logic                        read_valid,
	output creg_pkg::scalar_t           read_data,
	output logic                        redirect_valid,
	output creg_pkg::redirect_t         redirect,
	output creg_pkg::thread_bitmap_t    supervisor_en,
	output creg_pkg::thread_bitmap_t    mmu_en,
	output creg_pkg::thread_bitmap_t    interrupt_en,
	output logic [creg_pkg::THREADS_PER_CORE-1:0][creg_pkg::ASID_WIDTH-1:0] current_asid);

	import creg_pkg::*;

	logic rd_en;
	logic wr_en;
	logic eret_en;
	logic trap_en;
	thread_idx_t acc_thread;
	control_register_t acc_index;
	creg_value_u acc_value;
	trap_event_t trap;
	scalar_t eret_address;
	subcycle_t eret_subcycle;
	scalar_t trap_handler;
	scalar_t tlb_miss_handler;

	creg_access_port i_access_port(.*);

	control_registers #(.CORE_ID(CORE_ID)) i_control_registers(.*);

	trap_redirect i_trap_redirect(.*);

endmodule

// ==== tests/creg_subsys_tb.sv ====
// Table-driven testbench with CORE_ID fixed at 3
// Expected results trail their requests by two cycles
// Cycle-count reads are checked relative to each other only

`timescale 1ns/1ps

module creg_subsys_tb;

	import creg_pkg::*;

	localparam int CLK_PERIOD = 20;
	localparam int CORE_ID = 3;

	typedef struct packed {
		logic valid;
		creg_request_t req;
	} row_t;

	typedef struct packed {
		logic read_valid;
		logic is_count;
		scalar_t read_data;
		logic redirect_valid;
		redirect_t redirect;
		thread_bitmap_t sup;
		thread_bitmap_t mmu;
		thread_bitmap_t intr;
		logic [THREADS_PER_CORE-1:0][ASID_WIDTH-1:0] asid;
	} expect_t;

	logic clk;
	logic reset;
	logic req_valid;
	creg_request_t req;
	logic read_valid;
	scalar_t read_data;
	logic redirect_valid;
	redirect_t redirect;
	thread_bitmap_t supervisor_en;
	thread_bitmap_t mmu_en;
	thread_bitmap_t interrupt_en;
	logic [THREADS_PER_CORE-1:0][ASID_WIDTH-1:0] current_asid;

	row_t rows[$];
	expect_t pending[$];
	logic table_built = 1'b0;
	logic [15:0] lfsr = 16'd64520;
	int cycle = 0;
	logic count_seen = 1'b0;
	scalar_t count_val;
	int count_cycle;

	// Reference model flags held as {supervisor, mmu, interrupt}
	logic [2:0] m_flags[THREADS_PER_CORE] = '{default: 3'b100};
	logic [2:0] s_flags[THREADS_PER_CORE] = '{default: 3'b000};
	scalar_t m_reg[THREADS_PER_CORE][32] = '{default: '0};

	creg_subsys_top #(.CORE_ID(CORE_ID)) i_dut(.*);

	function automatic scalar_t random_bits(int nbits);
		scalar_t v;
		logic fb;
		v = '0;
		for (int i = 0; i < nbits; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic add_row(input creg_op_t op, input thread_idx_t t, input control_register_t idx,
		input scalar_t value = '0, input trap_reason_t reason = TR_RESET,
		input scalar_t pc = '0, input scalar_t addr = '0, input subcycle_t sub = '0);
		// Fields in request struct order
		rows.push_back({1'b1, op, t, idx, value, reason, pc, addr, sub});
	endtask

	task automatic build_table();
		control_register_t stored[7];
		creg_op_t user_ops[3];
		creg_value_u v;
		stored = '{CR_SCRATCHPAD0, CR_SCRATCHPAD1, CR_TRAP_HANDLER, CR_TLB_MISS_HANDLER,
			CR_TRAP_PC, CR_SUBCYCLE, CR_CURRENT_ASID};
		user_ops = '{OP_READ, OP_WRITE, OP_ERET};
		for (int t = 0; t < THREADS_PER_CORE; t++)
		begin
			add_row(OP_READ, t, CR_FLAGS);
			add_row(OP_READ, t, CR_TRAP_REASON);
		end
		for (int t = 0; t < THREADS_PER_CORE; t++)
			for (int k = 0; k < 7; k++)
			begin
				add_row(OP_WRITE, t, stored[k], random_bits(32));
				add_row(OP_READ, t, stored[k]);
			end
		// Reread everything once all threads hold their own values
		for (int t = 0; t < THREADS_PER_CORE; t++)
			for (int k = 0; k < 7; k++)
				add_row(OP_READ, t, stored[k]);
		v.raw = random_bits(32);
		v.flags.supervisor_en = 1'b1;
		add_row(OP_WRITE, 0, CR_FLAGS, v.raw);
		add_row(OP_READ, 0, CR_FLAGS);
		for (int t = 0; t < THREADS_PER_CORE; t++)
			add_row(OP_READ, t, CR_THREAD_ID);
		add_row(OP_READ, 1, control_register_t'(5'd20));
		add_row(OP_READ, 2, control_register_t'(5'd31));
		add_row(OP_READ, 0, CR_CYCLE_COUNT);
		repeat (3) rows.push_back('0);
		add_row(OP_READ, 0, CR_CYCLE_COUNT);
		// One trap per reason on thread 1 and a return after each
		for (int r = 0; r <= TR_SYSCALL; r++)
		begin
			add_row(OP_WRITE, 1, CR_FLAGS, 32'h7);
			add_row(OP_TRAP, 1, CR_THREAD_ID, '0, trap_reason_t'(r), random_bits(32),
				random_bits(32), subcycle_t'(random_bits(4)));
			add_row(OP_READ, 1, CR_SAVED_FLAGS);
			add_row(OP_READ, 1, CR_TRAP_REASON);
			add_row(OP_READ, 1, CR_TRAP_PC);
			add_row(OP_READ, 1, CR_TRAP_ADDRESS);
			add_row(OP_ERET, 1, CR_THREAD_ID);
			add_row(OP_READ, 1, CR_FLAGS);
		end
		add_row(OP_TRAP, 3, CR_THREAD_ID, '0, TR_SYSCALL, random_bits(32), '0, 4'd9);
		add_row(OP_WRITE, 3, CR_SAVED_FLAGS, 32'h6);
		add_row(OP_ERET, 3, CR_THREAD_ID);
		add_row(OP_READ, 3, CR_FLAGS);
		// Thread 2 drops to user mode before each access
		for (int k = 0; k < 3; k++)
		begin
			add_row(OP_WRITE, 2, CR_FLAGS, 32'h2);
			add_row(user_ops[k], 2, CR_SCRATCHPAD0, random_bits(32), TR_SYSCALL, random_bits(32));
		end
		add_row(OP_READ, 2, CR_SCRATCHPAD0);
		add_row(OP_READ, 2, CR_TRAP_REASON);
		add_row(OP_READ, 2, CR_FLAGS);
	endtask

	task automatic model_step(input row_t row, output expect_t e);
		creg_request_t r;
		thread_idx_t t;
		logic priv;
		logic tlb;
		r = row.req;
		t = r.thread;
		priv = r.op != OP_TRAP && !m_flags[t][2];
		tlb = !priv && (r.trap_reason == TR_ITLB_MISS || r.trap_reason == TR_DTLB_MISS);
		e = '0;
		if (row.valid && (r.op == OP_TRAP || priv))
		begin
			e.redirect_valid = 1'b1;
			e.redirect.thread = t;
			e.redirect.pc = m_reg[t][tlb ? CR_TLB_MISS_HANDLER : CR_TRAP_HANDLER];
			s_flags[t] = m_flags[t];
			// Supervisor on, interrupts off, MMU off only after a TLB miss
			m_flags[t] = {1'b1, m_flags[t][1] && !tlb, 1'b0};
			m_reg[t][CR_TRAP_PC] = r.trap_pc;
			m_reg[t][CR_TRAP_REASON] = priv ? scalar_t'(TR_PRIVILEGED_OP) : scalar_t'(r.trap_reason);
			m_reg[t][CR_TRAP_ADDRESS] = priv ? '0 : r.trap_addr;
			m_reg[t][CR_SUBCYCLE] = priv ? '0 : scalar_t'(r.subcycle);
		end
		else if (row.valid && r.op == OP_ERET)
		begin
			e.redirect_valid = 1'b1;
			e.redirect.thread = t;
			e.redirect.pc = m_reg[t][CR_TRAP_PC];
			e.redirect.subcycle = subcycle_t'(m_reg[t][CR_SUBCYCLE]);
			m_flags[t] = s_flags[t];
		end
		else if (row.valid && r.op == OP_WRITE)
		begin
			case (r.index)
				CR_FLAGS:        m_flags[t] = r.value.raw[2:0];
				CR_SAVED_FLAGS:  s_flags[t] = r.value.raw[2:0];
				CR_TRAP_HANDLER, CR_TLB_MISS_HANDLER:
					for (int i = 0; i < THREADS_PER_CORE; i++)
						m_reg[i][r.index] = r.value.raw;
				CR_TRAP_PC, CR_SCRATCHPAD0, CR_SCRATCHPAD1:
					m_reg[t][r.index] = r.value.raw;
				CR_SUBCYCLE:     m_reg[t][r.index] = scalar_t'(r.value.raw[3:0]);
				CR_CURRENT_ASID: m_reg[t][r.index] = scalar_t'(r.value.raw[ASID_WIDTH-1:0]);
				default:         ;
			endcase
		end
		else if (row.valid)
		begin
			e.read_valid = 1'b1;
			e.is_count = r.index == CR_CYCLE_COUNT;
			if (r.index == CR_THREAD_ID)
				e.read_data = scalar_t'(CORE_ID * THREADS_PER_CORE) + scalar_t'(t);
			else if (r.index == CR_FLAGS)
				e.read_data = scalar_t'(m_flags[t]);
			else if (r.index == CR_SAVED_FLAGS)
				e.read_data = scalar_t'(s_flags[t]);
			else if (r.index > CR_CURRENT_ASID)
				e.read_data = '1;
			else
				e.read_data = m_reg[t][r.index];
		end
		for (int i = 0; i < THREADS_PER_CORE; i++)
		begin
			{e.sup[i], e.mmu[i], e.intr[i]} = m_flags[i];
			e.asid[i] = m_reg[i][CR_CURRENT_ASID][ASID_WIDTH-1:0];
		end
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, exp, act);
		$display("TB FAILED");
		$fatal(1, "value mismatch on %s", name);
	endtask

	task automatic check_scalar(input string strobe_name, input string name,
		input logic exp_valid, input scalar_t exp, input logic act_valid, input scalar_t act);
		if (act_valid !== exp_valid)
			report_mismatch(strobe_name, 64'(exp_valid), 64'(act_valid));
		else if (exp_valid && act !== exp)
			report_mismatch(name, 64'(exp), 64'(act));
	endtask

	task automatic check_redirect(input logic exp_valid, input redirect_t exp,
		input logic act_valid, input redirect_t act);
		if (act_valid !== exp_valid)
			report_mismatch("redirect_valid", 64'(exp_valid), 64'(act_valid));
		else if (exp_valid && act !== exp)
			report_mismatch("redirect", 64'(exp), 64'(act));
	endtask

	task automatic check_flags(input string name, input thread_bitmap_t exp,
		input thread_bitmap_t act);
		if (act !== exp)
			report_mismatch(name, 64'(exp), 64'(act));
	endtask

	task automatic check_asid(input logic [THREADS_PER_CORE-1:0][ASID_WIDTH-1:0] exp,
		input logic [THREADS_PER_CORE-1:0][ASID_WIDTH-1:0] act);
		if (act !== exp)
			report_mismatch("current_asid", 64'(exp), 64'(act));
	endtask

	task automatic check_cycle(input expect_t e);
		if (e.is_count && read_valid)
		begin
			// First count read only fixes the reference point
			if (count_seen)
				e.read_data = count_val + scalar_t'(cycle - count_cycle);
			else
				e.read_data = read_data;
			count_seen = 1'b1;
			count_val = e.read_data;
			count_cycle = cycle;
		end
		check_scalar("read_valid", "read_data", e.read_valid, e.read_data, read_valid, read_data);
		check_redirect(e.redirect_valid, e.redirect, redirect_valid, redirect);
		check_flags("supervisor_en", e.sup, supervisor_en);
		check_flags("mmu_en", e.mmu, mmu_en);
		check_flags("interrupt_en", e.intr, interrupt_en);
		check_asid(e.asid, current_asid);
	endtask

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		wait (table_built);
		#((rows.size() + 20) * CLK_PERIOD);
		$display("Watchdog expired before all table rows were checked");
		$display("TB FAILED");
		$fatal(1, "timeout");
	end

	initial
	begin
		expect_t e;
		row_t row;
		reset = 1'b1;
		req_valid = 1'b0;
		req = '0;
		build_table();
		table_built = 1'b1;
		// Outputs of the first two cycles still show the reset state
		repeat (2)
		begin
			model_step('0, e);
			pending.push_back(e);
		end
		repeat (4) @(posedge clk);
		#2 reset = 1'b0;
		for (int i = 0; i < rows.size() + 2; i++)
		begin
			@(posedge clk);
			#2;
			row = i < rows.size() ? rows[i] : row_t'('0);
			req_valid = row.valid;
			req = row.req;
			model_step(row, e);
			pending.push_back(e);
			@(negedge clk);
			check_cycle(pending.pop_front());
			cycle++;
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== creg_subsys.f ====
logic/creg_pkg.sv
logic/creg_access_port.sv
logic/control_registers.sv
logic/trap_redirect.sv
logic/creg_subsys_top.sv
tests/creg_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= creg_subsys_tb
FILELIST ?= creg_subsys.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
